//--- include/convRegMap.svh
`ifndef convRegMapSvh
`define convRegMapSvh

////////////////////
// APB register map
////////////////////

// Control bits, enable and relu
`define regCtrl        8'h00

// Arithmetic right shift applied before saturation
`define regShift       8'h04

// Results produced, read only, a write clears it
`define regCount       8'h08

// First weight word, the rest follow at regStride
`define regWeight0     8'h10
`define regStride      4

// CTRL bit positions
`define ctrlEnableBit  0
`define ctrlReluBit    1

`endif

//--- hw/convPkg.sv
`default_nettype none

package convPkg;

    // Sample, weight and result width
    localparam int dataWidth  = 16;

    // Taps in the window
    localparam int tapCount   = 11;

    // Full precision of one signed product
    localparam int prodWidth  = 2 * dataWidth;

    // Four guard bits cover the sum of eleven products
    localparam int accWidth   = prodWidth + 4;

    // Shift field of the SHIFT register
    localparam int shiftWidth = 5;

    // One tap line, tap 0 is the newest sample
    // Flat view for shifting and latching, tap view for multiplying
    typedef union packed {
        logic [tapCount*dataWidth-1:0]      flat;
        logic [tapCount-1:0][dataWidth-1:0] taps;
    } tapLine_u;

endpackage

`default_nettype wire

//--- hw/convRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "convRegMap.svh"

module convRegs #(
    parameter int dataWidth = convPkg::dataWidth,
    parameter int tapCount  = convPkg::tapCount
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             psel,
    input  wire                             penable,
    input  wire                             pwrite,
    input  wire  [7:0]                      paddr,
    input  wire  [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    input  wire                             resultValid,
    output convPkg::tapLine_u               weights,
    output logic                            enable,
    output logic                            relu,
    output logic [convPkg::shiftWidth-1:0]  shiftAmount
);

    logic        writeAccess;
    logic [31:0] resultCount;

    // Zero wait state slave, writes land at the end of the access phase
    assign writeAccess = psel && penable && pwrite;

    function automatic logic [7:0] weightAddr(input int idx);
        return 8'(`regWeight0 + idx * `regStride);
    endfunction

    ////////////////////
    // Control and shift
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable      <= 1'b0;
            relu        <= 1'b0;
            shiftAmount <= '0;
        end else if (writeAccess) begin
            if (paddr == `regCtrl) begin
                enable <= pwdata[`ctrlEnableBit];
                relu   <= pwdata[`ctrlReluBit];
            end
            if (paddr == `regShift) begin
                shiftAmount <= pwdata[convPkg::shiftWidth-1:0];
            end
        end
    end

    ////////////////////
    // Weights
    ////////////////////

    // Low dataWidth bits of the write data hold the weight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            weights.flat <= '0;
        end else if (writeAccess) begin
            for (int i = 0; i < tapCount; i++) begin
                if (paddr == weightAddr(i)) begin
                    weights.taps[i] <= pwdata[dataWidth-1:0];
                end
            end
        end
    end

    // Result counter, a write to COUNT wins over a result in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultCount <= '0;
        end else if (writeAccess && (paddr == `regCount)) begin
            resultCount <= '0;
        end else if (resultValid) begin
            resultCount <= resultCount + 32'd1;
        end
    end

    ////////////////////
    // Read mux
    ////////////////////

    // Weights read back sign extended to the full word
    always_comb begin
        prdata = '0;
        case (paddr)
            `regCtrl: begin
                prdata[`ctrlEnableBit] = enable;
                prdata[`ctrlReluBit]   = relu;
            end
            `regShift: prdata[convPkg::shiftWidth-1:0] = shiftAmount;
            `regCount: prdata = resultCount;
            default: prdata = '0;
        endcase
        for (int i = 0; i < tapCount; i++) begin
            if (paddr == weightAddr(i)) begin
                prdata = {{(32-dataWidth){weights.taps[i][dataWidth-1]}}, weights.taps[i]};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/windowShifter.sv
`timescale 1ns/1ps
`default_nettype none

module windowShifter #(
    parameter int dataWidth = convPkg::dataWidth,
    parameter int tapCount  = convPkg::tapCount
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         enable,
    input  wire                         sampleValid,
    input  wire signed [dataWidth-1:0]  sampleData,
    output convPkg::tapLine_u           window,
    output logic                        windowValid
);

    localparam int fillWidth = $clog2(tapCount + 1);

    logic                 accept;
    logic [fillWidth-1:0] fillCount;

    assign accept = sampleValid && enable;

    // Newest sample enters at tap 0, the oldest drops off the top
    always_ff @(posedge clk) begin
        if (accept) begin
            window.flat <= {window.flat[(tapCount-1)*dataWidth-1:0], sampleData};
        end
    end

    ////////////////////
    // Fill tracking
    ////////////////////

    // Held at zero while disabled so a new fill starts when enable rises
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fillCount <= '0;
        end else if (!enable) begin
            fillCount <= '0;
        end else if (accept && (fillCount < fillWidth'(tapCount))) begin
            fillCount <= fillCount + 1'b1;
        end
    end

    // Strobe once the accepted sample completes a full window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            windowValid <= 1'b0;
        end else begin
            windowValid <= accept && (fillCount >= fillWidth'(tapCount - 1));
        end
    end

endmodule

`default_nettype wire

//--- hw/dotProduct11.sv
`timescale 1ns/1ps
`default_nettype none

module dotProduct11 #(
    parameter int dataWidth = convPkg::dataWidth,
    parameter int tapCount  = convPkg::tapCount
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  inValid,
    input  wire convPkg::tapLine_u               window,
    input  wire convPkg::tapLine_u               weights,
    output logic signed [convPkg::accWidth-1:0]  sum,
    output logic                                 sumValid
);

    convPkg::tapLine_u latchedWindow;
    convPkg::tapLine_u latchedWeights;

    logic stage1Valid;
    logic stage2Valid;

    logic signed [dataWidth-1:0]          windowTaps  [tapCount];
    logic signed [dataWidth-1:0]          weightTaps  [tapCount];
    logic signed [convPkg::prodWidth-1:0] products    [tapCount];
    logic signed [convPkg::accWidth-1:0]  productSum;

    // Valid bits travel with the data through all three stages
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stage1Valid <= 1'b0;
            stage2Valid <= 1'b0;
            sumValid    <= 1'b0;
        end else begin
            stage1Valid <= inValid;
            stage2Valid <= stage1Valid;
            sumValid    <= stage2Valid;
        end
    end

    ////////////////////
    // Stage 1
    ////////////////////

    // Weights are captured together with the window they apply to
    always_ff @(posedge clk) begin
        if (inValid) begin
            latchedWindow  <= window;
            latchedWeights <= weights;
        end
    end

    ////////////////////
    // Stage 2
    ////////////////////

    // Tap view read as signed words
    always_comb begin
        for (int i = 0; i < tapCount; i++) begin
            windowTaps[i] = latchedWindow.taps[i];
            weightTaps[i] = latchedWeights.taps[i];
        end
    end

    always_ff @(posedge clk) begin
        if (stage1Valid) begin
            for (int i = 0; i < tapCount; i++) begin
                products[i] <= windowTaps[i] * weightTaps[i];
            end
        end
    end

    ////////////////////
    // Stage 3
    ////////////////////

    // Products sign extend into the guard bits
    always_comb begin
        productSum = '0;
        for (int i = 0; i < tapCount; i++) begin
            productSum = productSum + products[i];
        end
    end

    always_ff @(posedge clk) begin
        if (stage2Valid) begin
            sum <= productSum;
        end
    end

endmodule

`default_nettype wire

//--- hw/outputScaler.sv
`timescale 1ns/1ps
`default_nettype none

module outputScaler #(
    parameter int dataWidth = convPkg::dataWidth
) (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 inValid,
    input  wire signed [convPkg::accWidth-1:0]  sum,
    input  wire                                 relu,
    input  wire        [convPkg::shiftWidth-1:0] shiftAmount,
    output logic                                resultValid,
    output logic signed [dataWidth-1:0]         resultData
);

    localparam int sumWidth = convPkg::accWidth;

    // Limits of the signed result range, widened to the sum
    localparam logic signed [sumWidth-1:0] satMax =
        {{(sumWidth-dataWidth+1){1'b0}}, {(dataWidth-1){1'b1}}};
    localparam logic signed [sumWidth-1:0] satMin =
        {{(sumWidth-dataWidth+1){1'b1}}, {(dataWidth-1){1'b0}}};

    logic signed [sumWidth-1:0] shifted;
    logic signed [sumWidth-1:0] rectified;
    logic signed [sumWidth-1:0] clipped;

    // Shift, then ReLU, then clip
    always_comb begin
        shifted   = sum >>> shiftAmount;
        rectified = (relu && shifted < 0) ? '0 : shifted;
        if (rectified > satMax) begin
            clipped = satMax;
        end else if (rectified < satMin) begin
            clipped = satMin;
        end else begin
            clipped = rectified;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            resultData <= clipped[dataWidth-1:0];
        end
    end

endmodule

`default_nettype wire

//--- hw/convLine.sv
`timescale 1ns/1ps
`default_nettype none

module convLine #(
    parameter int dataWidth = convPkg::dataWidth,
    parameter int tapCount  = convPkg::tapCount
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire  [7:0]                  paddr,
    input  wire  [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    input  wire                         sampleValid,
    input  wire signed [dataWidth-1:0]  sampleData,
    output logic                        resultValid,
    output logic signed [dataWidth-1:0] resultData
);

    convPkg::tapLine_u                    weights;
    convPkg::tapLine_u                    window;
    logic                                 enable;
    logic                                 relu;
    logic [convPkg::shiftWidth-1:0]       shiftAmount;
    logic                                 windowValid;
    logic signed [convPkg::accWidth-1:0]  sum;
    logic                                 sumValid;

    ////////////////////
    // Configuration
    ////////////////////

    // resultValid loops back to feed the COUNT register
    convRegs #(
        .dataWidth (dataWidth),
        .tapCount  (tapCount)
    ) regs0 (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .resultValid (resultValid),
        .weights     (weights),
        .enable      (enable),
        .relu        (relu),
        .shiftAmount (shiftAmount)
    );

    ////////////////////
    // Datapath
    ////////////////////

    // Window 1, products 3, scaler 1, five edges in all
    windowShifter #(
        .dataWidth (dataWidth),
        .tapCount  (tapCount)
    ) shifter0 (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .window      (window),
        .windowValid (windowValid)
    );

    dotProduct11 #(
        .dataWidth (dataWidth),
        .tapCount  (tapCount)
    ) dot0 (
        .clk      (clk),
        .rst      (rst),
        .inValid  (windowValid),
        .window   (window),
        .weights  (weights),
        .sum      (sum),
        .sumValid (sumValid)
    );

    outputScaler #(
        .dataWidth (dataWidth)
    ) scaler0 (
        .clk         (clk),
        .rst         (rst),
        .inValid     (sumValid),
        .sum         (sum),
        .relu        (relu),
        .shiftAmount (shiftAmount),
        .resultValid (resultValid),
        .resultData  (resultData)
    );

endmodule

`default_nettype wire

//--- verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verification/convLineAssert.sv
`timescale 1ns/1ps
`default_nettype none

module convLineAssert (
    input wire clk,
    input wire rst,
    input wire psel,
    input wire penable,
    input wire sampleValid,
    input wire enable,
    input wire windowValid,
    input wire resultValid
);

    logic [3:0] taken;
    int         failCount = 0;

    // Samples taken since enable rose, saturating at a full window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            taken <= '0;
        end else if (!enable) begin
            taken <= '0;
        end else if (sampleValid && (taken < 4'd11)) begin
            taken <= taken + 4'd1;
        end
    end

    ////////////////////
    // Pipeline timing
    ////////////////////

    windowToResult: assert property (@(posedge clk) disable iff (rst)
        windowValid |-> ##4 resultValid)
        else begin
            $error("resultValid did not follow windowValid after 4 cycles");
            failCount++;
        end

    resultFromWindow: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(windowValid, 4))
        else begin
            $error("resultValid without windowValid 4 cycles earlier");
            failCount++;
        end

    // Sample completing the window was the eleventh one
    noEarlyResult: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(sampleValid && enable && (taken >= 4'd10), 5))
        else begin
            $error("result appeared before 11 samples were taken");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) rst |-> !resultValid)
        else begin
            $error("resultValid high during reset");
            failCount++;
        end

    ////////////////////
    // APB protocol
    ////////////////////

    setupBeforeAccess: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> $past(psel && !penable))
        else begin
            $error("APB access phase without a setup phase");
            failCount++;
        end

endmodule

bind convLine convLineAssert assert0 (
    .clk         (clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .sampleValid (sampleValid),
    .enable      (enable),
    .windowValid (windowValid),
    .resultValid (resultValid)
);

`default_nettype wire

//--- verification/tbTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "convRegMap.svh"

module tbTop;

    localparam int dataWidth  = convPkg::dataWidth;
    localparam int tapCount   = convPkg::tapCount;

    // Rough cycles per test for the five tests
    localparam int testCycles = 60 + 260 + 130 + 70 + 150;
    localparam int cycleLimit = 2 * testCycles + 200;

    wire                         clk;
    wire                         rst;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [7:0]                  paddr;
    logic [31:0]                 pwdata;
    wire  [31:0]                 prdata;
    logic                        sampleValid;
    logic signed [dataWidth-1:0] sampleData;
    wire                         resultValid;
    wire  signed [dataWidth-1:0] resultData;

    // Reference model state
    int refWin [tapCount];
    int refWts [tapCount];
    int refShift;
    bit refRelu;
    bit refEnable;
    int refFill;
    int refCount;
    int expectQ [$];

    int weightVal [tapCount];
    int expected;
    int resultsSeen;
    int errorCount;
    int errorsBefore;
    int cycleCount;

    clockGen clk0 (
        .clk (clk),
        .rst (rst)
    );

    convLine #(
        .dataWidth (dataWidth),
        .tapCount  (tapCount)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .resultValid (resultValid),
        .resultData  (resultData)
    );

    function automatic int totalErrors();
        return errorCount + dut0.assert0.failCount;
    endfunction

    function automatic logic [7:0] weightAddr(input int idx);
        return 8'(`regWeight0 + idx * `regStride);
    endfunction

    // Random signed value of the given width sign extended to 32 bits
    function automatic int randSigned(input int bits);
        int r;
        r = $urandom;
        r = r <<< (32 - bits);
        return r >>> (32 - bits);
    endfunction

    // Sum of products, shift, ReLU, then clip to the result range
    function automatic int refResult();
        longint acc;
        longint maxVal;
        maxVal = (longint'(1) <<< (dataWidth - 1)) - 1;
        acc = 0;
        for (int i = 0; i < tapCount; i++) begin
            acc = acc + longint'(refWin[i]) * longint'(refWts[i]);
        end
        acc = acc >>> refShift;
        if (refRelu && acc < 0) begin
            acc = 0;
        end
        if (acc > maxVal) begin
            acc = maxVal;
        end else if (acc < -maxVal - 1) begin
            acc = -maxVal - 1;
        end
        return int'(acc);
    endfunction

    task automatic updateModel(input logic [7:0] addr, input logic [31:0] data);
        if (addr == `regCtrl) begin
            refEnable = data[`ctrlEnableBit];
            refRelu   = data[`ctrlReluBit];
            if (!refEnable) begin
                refFill = 0;
            end
        end else if (addr == `regShift) begin
            refShift = int'(data[convPkg::shiftWidth-1:0]);
        end else if (addr == `regCount) begin
            refCount = 0;
        end
        for (int i = 0; i < tapCount; i++) begin
            if (addr == weightAddr(i)) begin
                refWts[i] = int'($signed(data[dataWidth-1:0]));
            end
        end
    endtask

    ////////////////////
    // Bus and stream
    ////////////////////

    task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        updateModel(addr, data);
    endtask

    task automatic checkRead(input logic [7:0] addr, input logic [31:0] wantData);
        logic [31:0] data;
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;
        psel    = 1'b0;
        penable = 1'b0;
        assert (data == wantData) else begin
            errorCount++;
            $display("error %0t: read of 0x%02h gave 0x%08h, expected 0x%08h",
                     $time, addr, data, wantData);
        end
    endtask

    // Model shifts only what the DUT accepts
    task automatic sendSample(input int value);
        sampleValid = 1'b1;
        sampleData  = value[dataWidth-1:0];
        if (refEnable) begin
            for (int i = tapCount - 1; i > 0; i--) begin
                refWin[i] = refWin[i-1];
            end
            refWin[0] = value;
            if (refFill < tapCount) begin
                refFill++;
            end
            if (refFill == tapCount) begin
                expectQ.push_back(refResult());
                refCount++;
            end
        end
        @(negedge clk);
    endtask

    task automatic sendBurst(input int count, input int bits);
        for (int n = 0; n < count; n++) begin
            sendSample(randSigned(bits));
        end
        sampleValid = 1'b0;
    endtask

    task automatic sendConst(input int count, input int value);
        for (int n = 0; n < count; n++) begin
            sendSample(value);
        end
        sampleValid = 1'b0;
    endtask

    // Extra cycles let any stray result surface
    task automatic waitDrain();
        while (expectQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
    endtask

    task automatic endTest(input int num, input string name);
        waitDrain();
        $display("Test %0d %s: %s", num, name, (totalErrors() == errorsBefore) ? "ok" : "failed");
        errorsBefore = totalErrors();
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////

    always @(negedge clk) begin
        if (!rst && resultValid) begin
            resultsSeen++;
            assert (expectQ.size() > 0) else begin
                errorCount++;
                $display("Result %0d appeared at %0t with no window expected",
                         resultData, $time);
            end
            if (expectQ.size() > 0) begin
                expected = expectQ.pop_front();
                assert (resultData == expected) else begin
                    errorCount++;
                    $display("error %0t: result %0d, expected %0d", $time, resultData, expected);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hefc0_662d));
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sampleValid = 1'b0;
        sampleData  = '0;
        for (int i = 0; i < tapCount; i++) begin
            refWin[i] = 0;
            refWts[i] = 0;
        end
        refShift     = 0;
        refRelu      = 1'b0;
        refEnable    = 1'b0;
        refFill      = 0;
        refCount     = 0;
        resultsSeen  = 0;
        errorCount   = 0;
        errorsBefore = 0;
        cycleCount   = 0;
        @(negedge rst);
        @(negedge clk);

        // Impulse at tap 5 echoes the sample five steps back
        apbWrite(weightAddr(5), 32'd1);
        apbWrite(`regShift, 32'd0);
        apbWrite(`regCtrl, 32'h1);
        sendBurst(30, 16);
        endTest(1, "impulse weights");

        // Small weights keep most sums inside the result range
        for (int i = 0; i < tapCount; i++) begin
            apbWrite(weightAddr(i), randSigned(8));
        end
        apbWrite(`regShift, 32'd4);
        sendBurst(200, 12);
        endTest(2, "random burst");

        apbWrite(`regCtrl, 32'h0);
        for (int i = 0; i < tapCount; i++) begin
            apbWrite(weightAddr(i), 32'd30000);
        end
        apbWrite(`regShift, 32'd0);
        apbWrite(`regCtrl, 32'h1);
        sendConst(15, 20000);
        sendConst(11, -20000);
        waitDrain();
        // Negative weights turn the later sums negative for ReLU to clear
        for (int i = 0; i < tapCount; i++) begin
            apbWrite(weightAddr(i), -30000);
        end
        apbWrite(`regCtrl, 32'h3);
        sendConst(15, 20000);
        endTest(3, "relu and saturation");

        for (int i = 0; i < tapCount; i++) begin
            weightVal[i] = randSigned(16);
            apbWrite(weightAddr(i), weightVal[i]);
        end
        for (int i = 0; i < tapCount; i++) begin
            checkRead(weightAddr(i), weightVal[i]);
        end
        apbWrite(`regCtrl, 32'h3);
        checkRead(`regCtrl, 32'h3);
        apbWrite(`regShift, 32'd7);
        checkRead(`regShift, 32'd7);
        // Just past the last weight word
        checkRead(weightAddr(tapCount), 32'd0);
        checkRead(`regCount, refCount);
        apbWrite(`regCount, 32'd0);
        checkRead(`regCount, 32'd0);
        endTest(4, "register access");

        // Samples while disabled are dropped
        apbWrite(`regCtrl, 32'h0);
        sendBurst(5, 12);
        for (int i = 0; i < tapCount; i++) begin
            apbWrite(weightAddr(i), randSigned(8));
        end
        apbWrite(`regShift, 32'd2);
        apbWrite(`regCtrl, 32'h1);
        sendBurst(20, 12);
        waitDrain();
        apbWrite(`regCtrl, 32'h0);
        apbWrite(`regCtrl, 32'h1);
        for (int i = 0; i < tapCount; i++) begin
            apbWrite(weightAddr(i), randSigned(8));
        end
        sendBurst(15, 12);
        endTest(5, "enable toggle and weight change");

        $display("Results %0d, left over %0d, scoreboard errors %0d, assertion failures %0d",
                 resultsSeen, expectQ.size(), errorCount, dut0.assert0.failCount);
        if (totalErrors() == 0 && expectQ.size() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/convPkg.sv
hw/convRegs.sv
hw/windowShifter.sv
hw/dotProduct11.sv
hw/outputScaler.sv
hw/convLine.sv
verification/clockGen.sv
verification/convLineAssert.sv
verification/tbTop.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then let the log decide the result
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tbTop -o simTb \
    && ./obj_dir/simTb > sim.log 2>&1 \
    || echo "Build or simulation stopped early" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0
